// File: files.f
logic/conn_mgr_pkg.sv
logic/request_deframer.sv
logic/qpn_free_list.sv
logic/qp_conn_ctrl.sv
logic/reply_framer.sv
logic/conn_mgr_top.sv
tests/conn_mgr_assertions.sv
tests/tb_conn_mgr.sv

// File: logic/conn_mgr_pkg.sv
`default_nettype none

package conn_mgr_pkg;

    localparam int WORD_W = 32;
    localparam int QPN_W  = 24;
    localparam int PSN_W  = 24;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [QPN_W-1:0]  qpn_t;
    typedef logic [PSN_W-1:0]  psn_t;
    typedef logic [31:0]       rkey_t;
    typedef logic [31:0]       ip_addr_t;
    typedef logic [6:0]        req_type_t;
    typedef logic [1:0]        qp_status_t;

    // request and reply type codes
    localparam req_type_t REQ_NULL          = 7'd0;
    localparam req_type_t REQ_OPEN_QP       = 7'd1;
    localparam req_type_t REQ_MODIFY_QP_RTS = 7'd2;
    localparam req_type_t REQ_CLOSE_QP      = 7'd3;
    localparam req_type_t REQ_SEND_QP_INFO  = 7'd4;
    localparam req_type_t REQ_ERROR         = 7'd7;

    localparam qp_status_t QP_STATUS_OK = 2'd0;

    // frame lengths in words
    localparam int REQ_WORDS   = 7;
    localparam int REPLY_WORDS = 6;

endpackage

`default_nettype wire

// File: logic/conn_mgr_top.sv
`timescale 1ns/1ps
`default_nettype none

module conn_mgr_top #(
    parameter int                 MAX_QUEUE_PAIRS = 4,
    parameter conn_mgr_pkg::qpn_t QPN_BASE        = 24'h000010
) (
    input  wire                          clk,
    input  wire                          rst,
    input  conn_mgr_pkg::word_t          s_data,
    input  wire                          s_valid,
    output logic                         s_ready,
    input  wire                          s_last,
    output conn_mgr_pkg::word_t          m_data,
    output logic                         m_valid,
    input  wire                          m_ready,
    output logic                         m_last,
    output logic                         qp_init_valid,
    output conn_mgr_pkg::req_type_t      qp_init_req_type,
    output conn_mgr_pkg::rkey_t          qp_init_r_key,
    output conn_mgr_pkg::qpn_t           qp_init_rem_qpn,
    output conn_mgr_pkg::qpn_t           qp_init_loc_qpn,
    output conn_mgr_pkg::psn_t           qp_init_rem_psn,
    output conn_mgr_pkg::psn_t           qp_init_loc_psn,
    output conn_mgr_pkg::ip_addr_t       qp_init_rem_ip_addr,
    input  wire                          qp_init_status_valid,
    input  conn_mgr_pkg::qp_status_t     qp_init_status,
    input  conn_mgr_pkg::ip_addr_t       cfg_loc_ip_addr,
    output logic                         busy
);

    logic                    req_valid, req_ready;
    conn_mgr_pkg::req_type_t req_type;
    conn_mgr_pkg::qpn_t      req_loc_qpn, req_rem_qpn;
    conn_mgr_pkg::psn_t      req_loc_psn, req_rem_psn;
    conn_mgr_pkg::rkey_t     req_r_key;
    conn_mgr_pkg::ip_addr_t  req_loc_ip;

    logic                    free_valid, free_pop, ret_valid, ret_ready;
    conn_mgr_pkg::qpn_t      free_qpn, ret_qpn;

    logic                    rep_valid, rep_ready;
    conn_mgr_pkg::req_type_t rep_type;
    conn_mgr_pkg::qpn_t      rep_loc_qpn, rep_rem_qpn;
    conn_mgr_pkg::psn_t      rep_loc_psn, rep_rem_psn;
    conn_mgr_pkg::ip_addr_t  rep_loc_ip;

    request_deframer request_deframer_i (
        .clk(clk), .rst(rst),
        .s_data(s_data), .s_valid(s_valid), .s_last(s_last), .s_ready(s_ready),
        .req_valid(req_valid), .req_ready(req_ready), .req_type(req_type),
        .req_loc_qpn(req_loc_qpn), .req_loc_psn(req_loc_psn), .req_r_key(req_r_key),
        .req_loc_ip(req_loc_ip), .req_rem_qpn(req_rem_qpn), .req_rem_psn(req_rem_psn)
    );

    qpn_free_list #(
        .MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS),
        .QPN_BASE(QPN_BASE)
    ) qpn_free_list_i (
        .clk(clk), .rst(rst),
        .free_valid(free_valid), .free_qpn(free_qpn), .free_pop(free_pop),
        .ret_valid(ret_valid), .ret_qpn(ret_qpn), .ret_ready(ret_ready)
    );

    qp_conn_ctrl qp_conn_ctrl_i (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_type(req_type),
        .req_loc_qpn(req_loc_qpn), .req_loc_psn(req_loc_psn), .req_r_key(req_r_key),
        .req_loc_ip(req_loc_ip), .req_rem_qpn(req_rem_qpn), .req_rem_psn(req_rem_psn),
        .free_valid(free_valid), .free_qpn(free_qpn), .free_pop(free_pop),
        .ret_valid(ret_valid), .ret_qpn(ret_qpn), .ret_ready(ret_ready),
        .qp_init_valid(qp_init_valid), .qp_init_req_type(qp_init_req_type),
        .qp_init_r_key(qp_init_r_key), .qp_init_rem_qpn(qp_init_rem_qpn),
        .qp_init_loc_qpn(qp_init_loc_qpn), .qp_init_rem_psn(qp_init_rem_psn),
        .qp_init_loc_psn(qp_init_loc_psn), .qp_init_rem_ip_addr(qp_init_rem_ip_addr),
        .qp_init_status_valid(qp_init_status_valid), .qp_init_status(qp_init_status),
        .cfg_loc_ip_addr(cfg_loc_ip_addr),
        .rep_valid(rep_valid), .rep_ready(rep_ready), .rep_type(rep_type),
        .rep_loc_qpn(rep_loc_qpn), .rep_loc_psn(rep_loc_psn), .rep_loc_ip(rep_loc_ip),
        .rep_rem_qpn(rep_rem_qpn), .rep_rem_psn(rep_rem_psn),
        .busy(busy)
    );

    reply_framer reply_framer_i (
        .clk(clk), .rst(rst),
        .rep_valid(rep_valid), .rep_ready(rep_ready), .rep_type(rep_type),
        .rep_loc_qpn(rep_loc_qpn), .rep_loc_psn(rep_loc_psn), .rep_loc_ip(rep_loc_ip),
        .rep_rem_qpn(rep_rem_qpn), .rep_rem_psn(rep_rem_psn),
        .m_data(m_data), .m_valid(m_valid), .m_ready(m_ready), .m_last(m_last)
    );

endmodule

`default_nettype wire

// File: logic/qp_conn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module qp_conn_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          req_valid,
    output logic                         req_ready,
    input  conn_mgr_pkg::req_type_t      req_type,
    input  conn_mgr_pkg::qpn_t           req_loc_qpn,
    input  conn_mgr_pkg::psn_t           req_loc_psn,
    input  conn_mgr_pkg::rkey_t          req_r_key,
    input  conn_mgr_pkg::ip_addr_t       req_loc_ip,
    input  conn_mgr_pkg::qpn_t           req_rem_qpn,
    input  conn_mgr_pkg::psn_t           req_rem_psn,
    input  wire                          free_valid,
    input  conn_mgr_pkg::qpn_t           free_qpn,
    output logic                         free_pop,
    output logic                         ret_valid,
    output conn_mgr_pkg::qpn_t           ret_qpn,
    input  wire                          ret_ready,
    output logic                         qp_init_valid,
    output conn_mgr_pkg::req_type_t      qp_init_req_type,
    output conn_mgr_pkg::rkey_t          qp_init_r_key,
    output conn_mgr_pkg::qpn_t           qp_init_rem_qpn,
    output conn_mgr_pkg::qpn_t           qp_init_loc_qpn,
    output conn_mgr_pkg::psn_t           qp_init_rem_psn,
    output conn_mgr_pkg::psn_t           qp_init_loc_psn,
    output conn_mgr_pkg::ip_addr_t       qp_init_rem_ip_addr,
    input  wire                          qp_init_status_valid,
    input  conn_mgr_pkg::qp_status_t     qp_init_status,
    input  conn_mgr_pkg::ip_addr_t       cfg_loc_ip_addr,
    output logic                         rep_valid,
    input  wire                          rep_ready,
    output conn_mgr_pkg::req_type_t      rep_type,
    output conn_mgr_pkg::qpn_t           rep_loc_qpn,
    output conn_mgr_pkg::psn_t           rep_loc_psn,
    output conn_mgr_pkg::ip_addr_t       rep_loc_ip,
    output conn_mgr_pkg::qpn_t           rep_rem_qpn,
    output conn_mgr_pkg::psn_t           rep_rem_psn,
    output logic                         busy
);

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_WAIT_STATUS,
        STATE_SEND_REPLY
    } state_t;

    state_t state;
    logic   accept, is_open, is_known, pool_empty, start_cmd;
    logic   status_done, status_ok, reply_good;
    logic   cur_open, cur_close;   // type of the command in flight

    assign req_ready = state == STATE_IDLE;
    assign busy      = state != STATE_IDLE;
    assign accept    = req_valid && req_ready;
    assign is_open   = req_type == conn_mgr_pkg::REQ_OPEN_QP;
    assign is_known  = is_open || req_type == conn_mgr_pkg::REQ_MODIFY_QP_RTS ||
                       req_type == conn_mgr_pkg::REQ_CLOSE_QP;
    assign pool_empty = accept && is_open && !free_valid;
    assign start_cmd  = accept && is_known && !pool_empty;

    assign status_done = state == STATE_WAIT_STATUS && qp_init_status_valid;
    assign status_ok   = qp_init_status == conn_mgr_pkg::QP_STATUS_OK;
    assign reply_good  = status_done && status_ok && !(cur_close && !ret_ready);

    // pool only changes on a good status, head is still the captured qpn
    assign free_pop  = status_done && status_ok && cur_open;
    assign ret_valid = status_done && status_ok && cur_close && ret_ready;
    assign ret_qpn   = qp_init_loc_qpn;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= STATE_IDLE;
            qp_init_valid <= 1'b0;
            rep_valid     <= 1'b0;
        end else begin
            qp_init_valid <= start_cmd;
            case (state)
                STATE_IDLE: begin
                    if (start_cmd)
                        state <= STATE_WAIT_STATUS;
                    else if (pool_empty) begin
                        rep_valid <= 1'b1;
                        state     <= STATE_SEND_REPLY;
                    end
                end
                STATE_WAIT_STATUS: begin
                    if (status_done) begin
                        rep_valid <= 1'b1;
                        state     <= STATE_SEND_REPLY;
                    end
                end
                default: begin
                    if (rep_ready) begin
                        rep_valid <= 1'b0;
                        state     <= STATE_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_cmd) begin
            cur_open            <= is_open;
            cur_close           <= req_type == conn_mgr_pkg::REQ_CLOSE_QP;
            qp_init_req_type    <= req_type;
            qp_init_r_key       <= req_r_key;
            qp_init_rem_qpn     <= req_loc_qpn;     // local and remote swap
            qp_init_rem_psn     <= req_loc_psn;
            qp_init_rem_ip_addr <= req_loc_ip;
            qp_init_loc_qpn     <= is_open ? free_qpn : req_rem_qpn;
            qp_init_loc_psn     <= is_open ? '0 : req_rem_psn;
        end
        if (reply_good) begin
            rep_type    <= conn_mgr_pkg::REQ_SEND_QP_INFO;
            rep_loc_qpn <= qp_init_loc_qpn;
            rep_loc_psn <= qp_init_loc_psn;
            rep_loc_ip  <= cfg_loc_ip_addr;
            rep_rem_qpn <= qp_init_rem_qpn;
            rep_rem_psn <= qp_init_rem_psn;
        end else if (pool_empty || status_done) begin
            rep_type    <= conn_mgr_pkg::REQ_ERROR;
            rep_loc_qpn <= '0;
            rep_loc_psn <= '0;
            rep_loc_ip  <= '0;
            rep_rem_qpn <= '0;
            rep_rem_psn <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/qpn_free_list.sv
`timescale 1ns/1ps
`default_nettype none

module qpn_free_list #(
    parameter int                 MAX_QUEUE_PAIRS = 4,
    parameter conn_mgr_pkg::qpn_t QPN_BASE        = 24'h000010
) (
    input  wire                clk,
    input  wire                rst,
    output logic               free_valid,
    output conn_mgr_pkg::qpn_t free_qpn,
    input  wire                free_pop,
    input  wire                ret_valid,
    input  conn_mgr_pkg::qpn_t ret_qpn,
    output logic               ret_ready
);

    localparam int PTR_W = (MAX_QUEUE_PAIRS > 1) ? $clog2(MAX_QUEUE_PAIRS) : 1;
    localparam int CNT_W = $clog2(MAX_QUEUE_PAIRS + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(MAX_QUEUE_PAIRS - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(MAX_QUEUE_PAIRS);

    conn_mgr_pkg::qpn_t mem [MAX_QUEUE_PAIRS];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_pop;
    logic               do_push;

    assign free_valid = count != '0;
    assign ret_ready  = count != CNT_FULL;
    assign free_qpn   = mem[rd_ptr];
    assign do_pop     = free_pop && free_valid;
    assign do_push    = ret_valid && ret_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MAX_QUEUE_PAIRS; i++)
                mem[i] <= QPN_BASE + conn_mgr_pkg::qpn_t'(i);   // pool starts full
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= CNT_FULL;
        end else begin
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            if (do_push) begin
                mem[wr_ptr] <= ret_qpn;
                wr_ptr      <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

`default_nettype wire

// File: logic/reply_framer.sv
`timescale 1ns/1ps
`default_nettype none

module reply_framer (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rep_valid,
    output logic                         rep_ready,
    input  conn_mgr_pkg::req_type_t      rep_type,
    input  conn_mgr_pkg::qpn_t           rep_loc_qpn,
    input  conn_mgr_pkg::psn_t           rep_loc_psn,
    input  conn_mgr_pkg::ip_addr_t       rep_loc_ip,
    input  conn_mgr_pkg::qpn_t           rep_rem_qpn,
    input  conn_mgr_pkg::psn_t           rep_rem_psn,
    output conn_mgr_pkg::word_t          m_data,
    output logic                         m_valid,
    input  wire                          m_ready,
    output logic                         m_last
);

    localparam logic [2:0] LAST_IDX = 3'(conn_mgr_pkg::REPLY_WORDS - 1);

    logic                    full;
    logic [2:0]              idx;
    conn_mgr_pkg::req_type_t r_type;
    conn_mgr_pkg::qpn_t      r_loc_qpn, r_rem_qpn;
    conn_mgr_pkg::psn_t      r_loc_psn, r_rem_psn;
    conn_mgr_pkg::ip_addr_t  r_loc_ip;

    assign rep_ready = !full;
    assign m_valid   = full;
    assign m_last    = full && idx == LAST_IDX;

    always_comb begin
        case (idx)
            3'd0:    m_data = conn_mgr_pkg::word_t'(r_type);
            3'd1:    m_data = conn_mgr_pkg::word_t'(r_loc_qpn);
            3'd2:    m_data = conn_mgr_pkg::word_t'(r_loc_psn);
            3'd3:    m_data = r_loc_ip;
            3'd4:    m_data = conn_mgr_pkg::word_t'(r_rem_qpn);
            default: m_data = conn_mgr_pkg::word_t'(r_rem_psn);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            idx  <= '0;
        end else if (rep_valid && rep_ready) begin
            full <= 1'b1;
            idx  <= '0;
        end else if (m_valid && m_ready) begin
            if (m_last)
                full <= 1'b0;   // frame done
            else
                idx <= idx + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rep_valid && rep_ready) begin
            r_type    <= rep_type;
            r_loc_qpn <= rep_loc_qpn;
            r_loc_psn <= rep_loc_psn;
            r_loc_ip  <= rep_loc_ip;
            r_rem_qpn <= rep_rem_qpn;
            r_rem_psn <= rep_rem_psn;
        end
    end

endmodule

`default_nettype wire

// File: logic/request_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module request_deframer (
    input  wire                          clk,
    input  wire                          rst,
    input  conn_mgr_pkg::word_t          s_data,
    input  wire                          s_valid,
    input  wire                          s_last,
    output logic                         s_ready,
    output logic                         req_valid,
    input  wire                          req_ready,
    output conn_mgr_pkg::req_type_t      req_type,
    output conn_mgr_pkg::qpn_t           req_loc_qpn,
    output conn_mgr_pkg::psn_t           req_loc_psn,
    output conn_mgr_pkg::rkey_t          req_r_key,
    output conn_mgr_pkg::ip_addr_t       req_loc_ip,
    output conn_mgr_pkg::qpn_t           req_rem_qpn,
    output conn_mgr_pkg::psn_t           req_rem_psn
);

    localparam logic [2:0] LAST_IDX = 3'(conn_mgr_pkg::REQ_WORDS - 1);

    logic [2:0] word_cnt;
    logic       skip;   // dropping words past the last field
    logic       s_fire;

    assign s_ready = !req_valid;
    assign s_fire  = s_valid && s_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            word_cnt  <= '0;
            skip      <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            if (req_valid && req_ready)
                req_valid <= 1'b0;
            if (s_fire) begin
                if (skip) begin
                    skip <= !s_last;
                end else if (word_cnt == LAST_IDX) begin
                    word_cnt  <= '0;
                    req_valid <= 1'b1;
                    skip      <= !s_last;   // overlong frame, eat the tail
                end else if (s_last) begin
                    word_cnt <= '0;         // truncated, discard
                end else begin
                    word_cnt <= word_cnt + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire && !skip) begin
            case (word_cnt)
                3'd0: req_type    <= s_data[6:0];
                3'd1: req_loc_qpn <= s_data[23:0];
                3'd2: req_loc_psn <= s_data[23:0];
                3'd3: req_r_key   <= s_data;
                3'd4: req_loc_ip  <= s_data;
                3'd5: req_rem_qpn <= s_data[23:0];
                default: req_rem_psn <= s_data[23:0];
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_conn_mgr -f files.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_conn_mgr)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

// File: tests/conn_mgr_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module conn_mgr_assertions (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 qp_init_valid,
    input  wire                 busy,
    input  wire                 rep_valid,
    input  wire                 rep_ready,
    input  wire                 m_valid,
    input  wire                 m_ready,
    input  wire                 m_last,
    input  conn_mgr_pkg::word_t m_data
);

    init_single_pulse: assert property (@(posedge clk) disable iff (rst)
        qp_init_valid |=> !qp_init_valid)
        else $error("qp_init_valid was high in two consecutive cycles");

    reply_hold: assert property (@(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last))
        else $error("reply word changed while stalled");

    // stays busy until the reply record is handed over
    busy_hold: assert property (@(posedge clk) disable iff (rst)
        busy && !(rep_valid && rep_ready) |=> busy)
        else $error("busy dropped before the request finished");

endmodule

bind conn_mgr_top conn_mgr_assertions conn_mgr_assertions_i (
    .clk(clk),
    .rst(rst),
    .qp_init_valid(qp_init_valid),
    .busy(busy),
    .rep_valid(rep_valid),
    .rep_ready(rep_ready),
    .m_valid(m_valid),
    .m_ready(m_ready),
    .m_last(m_last),
    .m_data(m_data)
);

`default_nettype wire

// File: tests/conn_mgr_input.txt
// type loc_qpn loc_psn r_key loc_ip rem_qpn rem_psn, trunc status reply_flag, 6 reply words
// hex; trunc 0 sends all seven words, trunc n sends only the first n with s_last on the nth
1 101 1000 aaaa0001 a000001 0 0    0 0 1  4 10 0 c0a80001 101 1000
1 102 2000 aaaa0002 a000002 0 0    0 0 1  4 11 0 c0a80001 102 2000
1 103 3000 aaaa0003 a000003 0 0    0 0 1  4 12 0 c0a80001 103 3000
1 104 4000 aaaa0004 a000004 0 0    0 0 1  4 13 0 c0a80001 104 4000
1 105 5000 aaaa0005 a000005 0 0    0 0 1  7 0 0 0 0 0
2 101 1000 aaaa0001 a000001 10 500 0 0 1  4 10 500 c0a80001 101 1000
3 102 2000 aaaa0002 a000002 11 600 0 0 1  4 11 600 c0a80001 102 2000
3 104 4000 aaaa0004 a000004 13 700 0 0 1  4 13 700 c0a80001 104 4000
1 107 7000 aaaa0007 a000007 0 0    0 1 1  7 0 0 0 0 0
1 108 8000 aaaa0008 a000008 0 0    0 0 1  4 11 0 c0a80001 108 8000
1 109 9000 aaaa0009 a000009 0 0    3 0 0  0 0 0 0 0 0
5 109 9000 aaaa0009 a000009 0 0    0 0 0  0 0 0 0 0 0
1 109 9000 aaaa0009 a000009 0 0    0 0 1  4 13 0 c0a80001 109 9000
3 101 1000 aaaa0001 a000001 10 500 0 0 1  4 10 500 c0a80001 101 1000
3 108 8000 aaaa0008 a000008 11 800 0 0 1  4 11 800 c0a80001 108 8000
3 103 3000 aaaa0003 a000003 12 900 0 0 1  4 12 900 c0a80001 103 3000
3 109 9000 aaaa0009 a000009 13 a00 0 0 1  4 13 a00 c0a80001 109 9000
3 10a a000 aaaa000a a00000a 14 b00 0 0 1  7 0 0 0 0 0
2 10b b000 aaaa000b a00000b 10 500 0 2 1  7 0 0 0 0 0
1 10c c000 aaaa000c a00000c 0 0    0 0 1  4 10 0 c0a80001 10c c000
3 10c c000 aaaa000c a00000c 10 c00 6 0 0  0 0 0 0 0 0
1 10d d000 aaaa000d a00000d 0 0    0 0 1  4 11 0 c0a80001 10d d000
3 10d d000 aaaa000d a00000d 11 d00 0 3 1  7 0 0 0 0 0
1 10e e000 aaaa000e a00000e 0 0    0 0 1  4 12 0 c0a80001 10e e000
2 10e e000 aaaa000e a00000e 12 e00 0 0 1  4 12 e00 c0a80001 10e e000
1 10f f000 aaaa000f a00000f 0 0    0 0 1  4 13 0 c0a80001 10f f000
1 110 10000 aaaa0010 a000010 0 0   0 0 1  7 0 0 0 0 0
3 ff000120 ee005000 aaaa0011 a000011 11 f00 0 0 1  4 11 f00 c0a80001 120 5000
1 121 1100 aaaa0012 a000012 0 0    0 0 1  4 11 0 c0a80001 121 1100

// File: tests/tb_conn_mgr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conn_mgr;

    localparam int                 MAX_QUEUE_PAIRS = 4;
    localparam conn_mgr_pkg::qpn_t QPN_BASE        = 24'h000010;
    localparam int                 COLS            = 16;   // values per line of the data file
    localparam int                 MAX_LINES       = 64;
    localparam logic [31:0]        LOC_IP          = 32'hc0a8_0001;
    localparam logic [31:0]        FIELD_MASK      = 32'h00ff_ffff;

    logic                          clk;
    logic                          rst;
    conn_mgr_pkg::word_t           s_data;
    logic                          s_valid;
    logic                          s_ready;
    logic                          s_last;
    conn_mgr_pkg::word_t           m_data;
    logic                          m_valid;
    logic                          m_ready;
    logic                          m_last;
    logic                          qp_init_valid;
    conn_mgr_pkg::req_type_t       qp_init_req_type;
    conn_mgr_pkg::rkey_t           qp_init_r_key;
    conn_mgr_pkg::qpn_t            qp_init_rem_qpn;
    conn_mgr_pkg::qpn_t            qp_init_loc_qpn;
    conn_mgr_pkg::psn_t            qp_init_rem_psn;
    conn_mgr_pkg::psn_t            qp_init_loc_psn;
    conn_mgr_pkg::ip_addr_t        qp_init_rem_ip_addr;
    logic                          qp_init_status_valid;
    conn_mgr_pkg::qp_status_t      qp_init_status;
    conn_mgr_pkg::ip_addr_t        cfg_loc_ip_addr;
    logic                          busy;

    logic [31:0]        stim [COLS*MAX_LINES];
    int                 num_lines   = 0;
    logic               loaded      = 1'b0;
    logic [31:0]        lfsr        = 32'h10b0;
    logic [31:0]        cur_status  = '0;
    int                 err_value   = 0;
    int                 err_other   = 0;
    int                 init_count  = 0;
    int                 reply_count = 0;
    int                 rep_idx     = 0;
    logic [31:0]        rep_words [6];
    logic [31:0]        init_fields [7];   // type, r_key, rem_qpn, loc_qpn, rem_psn, loc_psn, rem_ip
    conn_mgr_pkg::qpn_t model_free [$];

    conn_mgr_top #(
        .MAX_QUEUE_PAIRS(MAX_QUEUE_PAIRS),
        .QPN_BASE(QPN_BASE)
    ) conn_mgr_top_i (.*);

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            err_value++;
        end
    endtask

    task automatic check_event(input logic ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            err_other++;
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
    endtask

    // caller is just past a rising edge
    task automatic send_word(input logic [31:0] data, input logic last);
        s_data  = data;
        s_valid = 1'b1;
        s_last  = last;
        @(negedge clk);
        while (!s_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        logic [31:0] bits;
        m_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            draw_bits(2, bits);
            m_ready = bits[1:0] != 2'b00;   // ready three cycles in four
        end
    end

    // QP state responder
    initial begin
        logic [31:0] bits;
        int          delay;
        qp_init_status_valid = 1'b0;
        qp_init_status       = '0;
        forever begin
            @(negedge clk);
            if (qp_init_valid) begin
                init_count++;
                init_fields[0] = 32'(qp_init_req_type);
                init_fields[1] = qp_init_r_key;
                init_fields[2] = 32'(qp_init_rem_qpn);
                init_fields[3] = 32'(qp_init_loc_qpn);
                init_fields[4] = 32'(qp_init_rem_psn);
                init_fields[5] = 32'(qp_init_loc_psn);
                init_fields[6] = qp_init_rem_ip_addr;
                draw_bits(3, bits);
                delay = int'(bits[2:0]) + 1;
                repeat (delay) @(posedge clk);
                #1;
                qp_init_status_valid = 1'b1;
                qp_init_status       = cur_status[1:0];
                @(posedge clk);
                #1;
                qp_init_status_valid = 1'b0;
            end
        end
    end

    // reply collector
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && m_valid && m_ready) begin
                if (rep_idx < 6)
                    rep_words[rep_idx] = m_data;
                if (m_last) begin
                    check_event(rep_idx == 5, "reply frame ended at a word other than the sixth");
                    rep_idx = 0;
                    reply_count++;
                end else begin
                    check_event(rep_idx < 5, "reply frame ran past six words without m_last");
                    rep_idx++;
                end
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (200 * ((num_lines > 0) ? num_lines : 1)) @(posedge clk);
        $display("timeout: the run did not finish in the cycles allowed for the data file");
        print_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int                      base;
        int                      n_words;
        int                      init_before;
        int                      rep_before;
        logic                    is_open;
        logic                    is_close;
        logic                    known;
        logic                    expect_cmd;
        logic                    expect_reply;
        logic [31:0]             exp_loc_qpn;
        logic [31:0]             exp_loc_psn;
        conn_mgr_pkg::req_type_t rtype;

        rst             = 1'b1;
        s_data          = '0;
        s_valid         = 1'b0;
        s_last          = 1'b0;
        cfg_loc_ip_addr = LOC_IP;
        for (int i = 0; i < COLS * MAX_LINES; i++)
            stim[i] = 32'hffff_0000 | 32'(i);   // marks lines the file did not fill
        $readmemh("tests/conn_mgr_input.txt", stim);
        while (num_lines < MAX_LINES && stim[num_lines * COLS + 7][31:16] != 16'hffff)
            num_lines++;
        loaded = 1'b1;
        for (int i = 0; i < MAX_QUEUE_PAIRS; i++)
            model_free.push_back(QPN_BASE + conn_mgr_pkg::qpn_t'(i));

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_event(s_ready && !busy && !m_valid && !qp_init_valid,
                    "outputs not at their idle values after reset");
        check_event(num_lines > 0, "no test lines were read from the data file");
        @(posedge clk);
        #1;

        for (int ln = 0; ln < num_lines; ln++) begin
            base         = ln * COLS;
            rtype        = stim[base][6:0];
            is_open      = rtype == conn_mgr_pkg::REQ_OPEN_QP;
            is_close     = rtype == conn_mgr_pkg::REQ_CLOSE_QP;
            known        = is_open || is_close || rtype == conn_mgr_pkg::REQ_MODIFY_QP_RTS;
            n_words      = (stim[base + 7] == 0) ? 7 : int'(stim[base + 7]);
            expect_cmd   = n_words == 7 && known && !(is_open && model_free.size() == 0);
            expect_reply = stim[base + 9] != 0;
            cur_status   = stim[base + 8];
            init_before  = init_count;
            rep_before   = reply_count;

            for (int k = 0; k < n_words; k++)
                send_word(stim[base + k], k == n_words - 1);
            if (expect_reply)
                wait (reply_count != rep_before);
            else
                repeat (12) @(posedge clk);   // window in which nothing may happen
            @(posedge clk);
            #1;

            check_event(init_count == init_before + (expect_cmd ? 1 : 0),
                        $sformatf("line %0d: wrong number of init commands", ln + 1));
            check_event(reply_count == rep_before + (expect_reply ? 1 : 0),
                        $sformatf("line %0d: wrong number of reply frames", ln + 1));

            if (expect_cmd) begin
                if (is_open) begin
                    exp_loc_qpn = 32'(model_free[0]);
                    exp_loc_psn = '0;
                end else begin
                    exp_loc_qpn = stim[base + 5] & FIELD_MASK;
                    exp_loc_psn = stim[base + 6] & FIELD_MASK;
                end
                check_value("qp_init_req_type", init_fields[0], stim[base] & 32'h7f);
                check_value("qp_init_r_key", init_fields[1], stim[base + 3]);
                check_value("qp_init_rem_qpn", init_fields[2], stim[base + 1] & FIELD_MASK);
                check_value("qp_init_loc_qpn", init_fields[3], exp_loc_qpn);
                check_value("qp_init_rem_psn", init_fields[4], stim[base + 2] & FIELD_MASK);
                check_value("qp_init_loc_psn", init_fields[5], exp_loc_psn);
                check_value("qp_init_rem_ip_addr", init_fields[6], stim[base + 4]);
            end

            if (expect_reply && reply_count == rep_before + 1) begin
                for (int k = 0; k < 6; k++)
                    check_value($sformatf("m_data[%0d]", k), rep_words[k], stim[base + 10 + k]);
            end

            // pool only changes on a good status
            if (expect_cmd && cur_status == 0) begin
                if (is_open)
                    void'(model_free.pop_front());
                else if (is_close && model_free.size() < MAX_QUEUE_PAIRS)
                    model_free.push_back(stim[base + 5][23:0]);
            end
        end

        print_counts();
        if (err_value == 0 && err_other == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
